// File: verilog.f
+incdir+hw
hw/fpu_pkg.sv
hw/fpu_op_decode.sv
hw/fpu_issue_buffer.sv
hw/fpu_sgnj_unit.sv
hw/fpu_cmp_unit.sv
hw/fpu_result_merge.sv
hw/fpu_nc_top.sv
bench/fpu_nc_assertions.sv
bench/fpu_nc_tb.sv

// File: Makefile
# Verilator build and run of the FP32 non-computational unit testbench

VERILATOR ?= verilator
TOP       ?= fpu_nc_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/fpu_nc_tb.sv
// Testbench of the FP32 non-computational unit: LCG stimulus, reference model and scoreboard
`timescale 1ns/1ps
`include "fpu_defines.svh"

module fpu_nc_tb;

    logic clk_i = 1'b0, rst_ni = 1'b0, flush_i = 1'b0, in_valid_i = 1'b0, out_ready_i = 1'b1;
    logic              in_ready_o, out_valid_o;
    fpu_pkg::fpu_req_t in_req_i = '0;
    fpu_pkg::fpu_rsp_t out_rsp_o, exp_rsp;
    fpu_pkg::fpu_rsp_t exp_q[$];      // Expected responses in issue order
    int                cyc_q[$];      // Acceptance cycle of each entry
    int   cycle = 0, acc_cyc, errors = 0, checks = 0, err_before;
    int   ready_mode = 0;             // 0 always ready, 1 random, 2 stalled
    logic lat_check = 1'b0;
    logic [31:0] seed = 32'hd844_1c31, rdy_seed = 32'hd844_1c31;
    logic [2:0]  tag_cnt = '0;
    logic [31:0] class_vals [10];

    always #4 clk_i = ~clk_i;  // 8 ns period

    fpu_nc_top u_fpu_nc_top (.*);

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Random word, about a quarter forced to a special value
    function automatic logic [31:0] rand_operand();
        seed = lcg(seed);
        if (seed[31:30] != 2'd0) return lcg(seed ^ 32'h5a5a_0f0f);
        case (seed[4:2])
            3'd0: return 32'h0000_0000;
            3'd1: return 32'h8000_0000;
            3'd2: return 32'h7F80_0000;
            3'd3: return 32'hFF80_0000;
            3'd4: return 32'h7F80_0001;  // sNaN
            3'd5: return 32'hFFC0_0000;  // qNaN
            3'd6: return 32'h0000_0123;
            default: return 32'h8040_0000;
        endcase
    endfunction

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    function automatic fpu_pkg::fpu_rsp_t fpu_ref(input fpu_pkg::fpu_req_t req);
        fpu_pkg::fpu_rsp_t r;
        logic [31:0] a, b, ka, kb;
        logic        an, bn, as, bs, bz;
        int          idx;
        a  = req.operand_a;
        b  = req.operand_b;
        r  = '0;
        r.tag = req.tag;
        an = (a[30:23] == 8'hFF) && (a[22:0] != 0);
        bn = (b[30:23] == 8'hFF) && (b[22:0] != 0);
        as = an && !a[22];
        bs = bn && !b[22];
        ka = a[31] ? ~a : (a | 32'h8000_0000);  // Monotonic key, -0 below +0
        kb = b[31] ? ~b : (b | 32'h8000_0000);
        bz = (a[30:0] == 0) && (b[30:0] == 0);
        case (req.op)
            fpu_pkg::FSGNJ: begin
                case (req.rm[1:0])
                    2'd0: r.result = {b[31], a[30:0]};
                    2'd1: r.result = {~b[31], a[30:0]};
                    2'd2: r.result = {a[31] ^ b[31], a[30:0]};
                    default: r.result = a;
                endcase
            end
            fpu_pkg::FMIN_MAX: begin
                if (an && bn) r.result = `FPU_CANON_NAN;
                else if (an) r.result = b;
                else if (bn) r.result = a;
                else if (req.rm[0]) r.result = (ka > kb) ? a : b;
                else r.result = (ka < kb) ? a : b;
                r.status[`FPU_ST_NV] = as || bs;
            end
            fpu_pkg::FCMP: begin
                case (req.rm[1:0])
                    2'd0: r.result[0] = !(an || bn) && ((ka <= kb) || bz);
                    2'd1: r.result[0] = !(an || bn) && (ka < kb) && !bz;
                    2'd2: r.result[0] = !(an || bn) && ((a == b) || bz);
                    default: r.result = '0;
                endcase
                if (req.rm[1:0] == 2'd2) r.status[`FPU_ST_NV] = as || bs;
                else if (req.rm[1:0] != 2'd3) r.status[`FPU_ST_NV] = an || bn;
            end
            fpu_pkg::FCLASS: begin
                if (an) idx = as ? 8 : 9;
                else if (a[30:23] == 8'hFF) idx = a[31] ? 0 : 7;
                else if (a[30:23] == 8'h00)
                    idx = (a[22:0] == 0) ? (a[31] ? 3 : 4) : (a[31] ? 2 : 5);
                else idx = a[31] ? 1 : 6;
                r.result = 32'd1 << idx;
            end
            default: r.result = a;  // Both moves
        endcase
        return r;
    endfunction

    // ----------------------------------------
    // Scoreboard and output ready
    // ----------------------------------------
    always @(posedge clk_i) begin
        cycle++;
        if (rst_ni && in_valid_i && in_ready_o) begin
            exp_q.push_back(fpu_ref(in_req_i));
            cyc_q.push_back(cycle);
        end
        if (rst_ni && out_valid_o && out_ready_i) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Response at %0t arrived with no request outstanding", $time);
            end else begin
                exp_rsp = exp_q.pop_front();
                acc_cyc = cyc_q.pop_front();
                checks++;
                if (out_rsp_o !== exp_rsp) begin
                    errors++;
                    $display("** Error at %0t: out_rsp_o expected %h got %h",
                             $time, exp_rsp, out_rsp_o);
                end
                if (lat_check && (cycle - acc_cyc != 2)) begin
                    errors++;
                    $display("** Error at %0t: out_valid_o latency expected 2 got %0d",
                             $time, cycle - acc_cyc);
                end
            end
        end
    end

    always @(posedge clk_i) begin
        #1;
        rdy_seed = lcg(rdy_seed);
        out_ready_i = (ready_mode == 0) ? 1'b1 : (ready_mode == 1) ? rdy_seed[16] : 1'b0;
    end

    task automatic abort_run(input string what);
        $display("Timeout while waiting for %s at %0t", what, $time);
        $display("Regression failed");
        $finish;
    endtask

    // Called 1 ns after a rising edge, returns 1 ns after the accepting edge
    task automatic send(input fpu_pkg::fpu_op_e op, input logic [2:0] rm,
                        input logic [31:0] a, input logic [31:0] b);
        int cnt;
        cnt = 0;
        in_req_i = '{op: op, rm: rm, operand_a: a, operand_b: b, tag: tag_cnt};
        tag_cnt++;
        in_valid_i = 1'b1;
        @(negedge clk_i);
        while (!in_ready_o && cnt < 100) begin
            @(negedge clk_i);
            cnt++;
        end
        if (cnt >= 100) abort_run("in_ready_o");
        @(posedge clk_i);
        #1 in_valid_i = 1'b0;
    endtask

    task automatic drain_and_report(input int num, input string name);
        int cnt;
        cnt = 0;
        while (exp_q.size() != 0 && cnt < 500) begin
            @(posedge clk_i);
            cnt++;
        end
        if (cnt >= 500) abort_run("outstanding responses");
        #1;
        $display("Test %0d %s: %s", num, name, (errors == err_before) ? "ok" : "errors");
        err_before = errors;
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        class_vals = '{32'hFF80_0000, 32'hBF80_0000, 32'h8000_0001, 32'h8000_0000, 32'h0,
                       32'h0000_0001, 32'h3F80_0000, 32'h7F80_0000, 32'h7F80_0001, 32'h7FC0_0000};
        err_before = 0;
        repeat (8) @(posedge clk_i);
        #1 rst_ni = 1'b1;

        for (int i = 0; i < 32; i++)
            send(fpu_pkg::FSGNJ, 3'(i), rand_operand(), rand_operand());
        send(fpu_pkg::FMV_F2X, 3'd5, rand_operand(), rand_operand());
        send(fpu_pkg::FMV_X2F, 3'd2, rand_operand(), rand_operand());
        drain_and_report(1, "sign injection and moves");
        for (int i = 0; i < 60; i++)
            send(fpu_pkg::FMIN_MAX, 3'(i), rand_operand(), rand_operand());
        send(fpu_pkg::FMIN_MAX, 3'd0, 32'h8000_0000, 32'h0);  // Signed zeros
        send(fpu_pkg::FMIN_MAX, 3'd1, 32'h0, 32'h8000_0000);
        send(fpu_pkg::FMIN_MAX, 3'd0, 32'h7F80_0001, 32'hFFC0_0000);  // Both NaN
        send(fpu_pkg::FMIN_MAX, 3'd1, 32'h7FC0_0000, 32'hC000_0000);  // One quiet NaN
        drain_and_report(2, "min/max");
        for (int i = 0; i < 80; i++)
            send(fpu_pkg::FCMP, 3'(i), rand_operand(), rand_operand());
        for (int i = 0; i < 4; i++) begin  // Equal values, zeros and NaN pairs
            send(fpu_pkg::FCMP, 3'(i), 32'hC040_0000, 32'hC040_0000);
            send(fpu_pkg::FCMP, 3'(i), 32'h8000_0000, 32'h0000_0000);
            send(fpu_pkg::FCMP, 3'(i), 32'h7FC0_0000, 32'h7FC0_0000);
            send(fpu_pkg::FCMP, 3'(i), 32'h7F80_0001, 32'h3F80_0000);
        end
        drain_and_report(3, "comparisons");
        for (int i = 0; i < 10; i++) send(fpu_pkg::FCLASS, 3'd0, class_vals[i], rand_operand());
        drain_and_report(4, "classify");

        lat_check = 1'b1;  // Back-to-back with ready high
        for (int i = 0; i < 20; i++)
            send(fpu_pkg::fpu_op_e'(i % 6), 3'(i), rand_operand(), rand_operand());
        drain_and_report(5, "latency");
        lat_check = 1'b0;
        ready_mode = 1;
        for (int i = 0; i < 80; i++)
            send(fpu_pkg::fpu_op_e'(i % 6), 3'(i), rand_operand(), rand_operand());
        drain_and_report(6, "random back-pressure");

        ready_mode = 2;  // Fill output, unit and hold register
        @(posedge clk_i);
        #1;
        for (int i = 0; i < 3; i++) send(fpu_pkg::FSGNJ, 3'd1, rand_operand(), rand_operand());
        if (in_ready_o || !out_valid_o) begin
            errors++;
            $display("Pipeline did not fill under back-pressure at %0t", $time);
        end
        flush_i = 1'b1;
        @(posedge clk_i);
        #1 flush_i = 1'b0;
        exp_q.delete();
        cyc_q.delete();
        if (!in_ready_o || out_valid_o) begin
            errors++;
            $display("Flush left in_ready_o low or a result still valid at %0t", $time);
        end
        ready_mode = 0;
        for (int i = 0; i < 8; i++) send(fpu_pkg::FCMP, 3'(i), rand_operand(), rand_operand());
        drain_and_report(7, "flush");

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0 && checks > 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: bench/fpu_nc_assertions.sv
// Concurrent protocol checks on the top-level ports, attached to fpu_nc_top with bind
`timescale 1ns/1ps
`include "fpu_defines.svh"

module fpu_nc_assertions (
    input logic              clk_i,
    input logic              rst_ni,
    input logic              flush_i,
    input logic              in_ready_o,
    input logic              out_valid_o,
    input logic              out_ready_i,
    input fpu_pkg::fpu_rsp_t out_rsp_o
);

    // ----------------------------------------
    // Reset behavior
    // ----------------------------------------
    // Output empty and input open on the first edge out of reset
    a_reset_empty : assert property (@(posedge clk_i)
        $rose(rst_ni) |-> (!out_valid_o && in_ready_o))
        else $error("out_valid_o high or in_ready_o low right after reset");

    // ----------------------------------------
    // Output handshake
    // ----------------------------------------
    a_out_hold : assert property (@(posedge clk_i) disable iff (!rst_ni)
        (out_valid_o && !out_ready_i && !flush_i) |=> (out_valid_o && $stable(out_rsp_o)))
        else $error("out_rsp_o changed under back-pressure");

    // Held item leaves once the consumer drains
    a_ready_recovers : assert property (@(posedge clk_i) disable iff (!rst_ni)
        (!in_ready_o && out_ready_i) |-> ##[1:2] in_ready_o)
        else $error("in_ready_o stuck low with out_ready_i high");

endmodule

bind fpu_nc_top fpu_nc_assertions u_fpu_nc_assertions (
    .clk_i, .rst_ni, .flush_i, .in_ready_o, .out_valid_o, .out_ready_i, .out_rsp_o
);

// File: hw/fpu_nc_top.sv
// Top level of the FP32 non-computational unit: decode, issue buffer, two units and output stage
`timescale 1ns/1ps

module fpu_nc_top (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              flush_i,
    input  logic              in_valid_i,
    output logic              in_ready_o,
    input  fpu_pkg::fpu_req_t in_req_i,
    output logic              out_valid_o,
    input  logic              out_ready_i,
    output fpu_pkg::fpu_rsp_t out_rsp_o
);

    fpu_pkg::fpu_uop_t dec_uop, iss_uop;
    logic              sgnj_issue, cmp_issue;   // Steered valids into stage 1
    logic              advance;                 // Common stage-1 enable
    logic              sgnj_valid, cmp_valid;
    fpu_pkg::fpu_rsp_t sgnj_rsp, cmp_rsp;

    fpu_op_decode u_op_decode (.req_i(in_req_i), .uop_o(dec_uop));

    fpu_issue_buffer u_issue_buffer (
        .clk_i, .rst_ni, .flush_i,
        .in_valid_i, .in_ready_o, .uop_i(dec_uop),
        .sgnj_valid_o(sgnj_issue), .cmp_valid_o(cmp_issue),
        .unit_ready_i(advance), .uop_o(iss_uop)
    );

    // ----------------------------------------
    // Execution units side by side
    // ----------------------------------------
    fpu_sgnj_unit u_sgnj_unit (
        .clk_i, .rst_ni, .flush_i, .valid_i(sgnj_issue), .advance_i(advance),
        .uop_i(iss_uop), .valid_o(sgnj_valid), .rsp_o(sgnj_rsp)
    );

    fpu_cmp_unit u_cmp_unit (
        .clk_i, .rst_ni, .flush_i, .valid_i(cmp_issue), .advance_i(advance),
        .uop_i(iss_uop), .valid_o(cmp_valid), .rsp_o(cmp_rsp)
    );

    fpu_result_merge u_result_merge (
        .clk_i, .rst_ni, .flush_i,
        .sgnj_valid_i(sgnj_valid), .sgnj_rsp_i(sgnj_rsp),
        .cmp_valid_i(cmp_valid), .cmp_rsp_i(cmp_rsp), .ready_o(advance),
        .out_valid_o, .out_ready_i, .out_rsp_o
    );

endmodule

// File: hw/fpu_result_merge.sv
// Output register that takes the valid unit response and drives the valid/ready output port
`timescale 1ns/1ps

module fpu_result_merge (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              flush_i,
    input  logic              sgnj_valid_i,
    input  fpu_pkg::fpu_rsp_t sgnj_rsp_i,
    input  logic              cmp_valid_i,
    input  fpu_pkg::fpu_rsp_t cmp_rsp_i,
    output logic              ready_o,
    output logic              out_valid_o,
    input  logic              out_ready_i,
    output fpu_pkg::fpu_rsp_t out_rsp_o
);

    logic              any_valid;
    fpu_pkg::fpu_rsp_t rsp_d;

    // At most one unit holds an item, so a plain select is enough
    assign any_valid = sgnj_valid_i || cmp_valid_i;
    assign rsp_d     = sgnj_valid_i ? sgnj_rsp_i : cmp_rsp_i;

    // Register free or being drained, doubles as the stage-advance signal
    assign ready_o = !out_valid_o || out_ready_i;

    // ----------------------------------------
    // Output register
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin : p_valid
        if (!rst_ni) begin
            out_valid_o <= 1'b0;
        end else if (flush_i) begin
            out_valid_o <= 1'b0;
        end else if (ready_o) begin
            out_valid_o <= any_valid;
        end
    end

    // Held steady while the consumer stalls
    always_ff @(posedge clk_i) begin : p_data
        if (ready_o && any_valid) out_rsp_o <= rsp_d;
    end

endmodule

// File: hw/fpu_cmp_unit.sv
// Min/max, comparisons and classification of FP32 operands with NV flag, one pipeline register
`timescale 1ns/1ps
`include "fpu_defines.svh"

module fpu_cmp_unit (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              flush_i,
    input  logic              valid_i,
    input  logic              advance_i,
    input  fpu_pkg::fpu_uop_t uop_i,
    output logic              valid_o,
    output fpu_pkg::fpu_rsp_t rsp_o
);

    fpu_pkg::fp32_u    a, b;
    logic              a_exp_max, b_exp_max, a_exp_zero;
    logic              a_nan, b_nan, a_snan, b_snan, any_nan, any_snan;
    logic              both_zero, mag_lt, bits_eq;
    logic              a_lt_tot;   // Total order, -0 below +0
    logic              a_lt_b, a_eq_b;
    logic [9:0]        class_mask;
    fpu_pkg::fpu_rsp_t rsp_d;

    assign a = uop_i.operand_a;
    assign b = uop_i.operand_b;

    // ----------------------------------------
    // Operand classes
    // ----------------------------------------
    assign a_exp_max  = &a.fields.exponent;
    assign b_exp_max  = &b.fields.exponent;
    assign a_exp_zero = ~|a.fields.exponent;
    assign a_nan      = a_exp_max && |a.fields.mantissa;
    assign b_nan      = b_exp_max && |b.fields.mantissa;
    assign a_snan     = a_nan && !a.fields.mantissa[22];  // Quiet bit clear
    assign b_snan     = b_nan && !b.fields.mantissa[22];
    assign any_nan    = a_nan || b_nan;
    assign any_snan   = a_snan || b_snan;
    assign both_zero  = ~|a.raw[`FPU_FLEN-2:0] && ~|b.raw[`FPU_FLEN-2:0];

    // Sign-magnitude ordering on the raw bits
    assign mag_lt   = a.raw[`FPU_FLEN-2:0] < b.raw[`FPU_FLEN-2:0];
    assign bits_eq  = a.raw == b.raw;
    assign a_lt_tot = (a.fields.sign != b.fields.sign) ? a.fields.sign
                    : (a.fields.sign ? (!mag_lt && !bits_eq) : mag_lt);
    assign a_lt_b   = a_lt_tot && !both_zero;  // Zeros compare equal
    assign a_eq_b   = bits_eq || both_zero;

    // RISC-V class bits, -inf at bit 0 up to qNaN at bit 9
    assign class_mask[0] = a.fields.sign && a_exp_max && ~|a.fields.mantissa;
    assign class_mask[1] = a.fields.sign && !a_exp_max && !a_exp_zero;
    assign class_mask[2] = a.fields.sign && a_exp_zero && |a.fields.mantissa;
    assign class_mask[3] = a.fields.sign && a_exp_zero && ~|a.fields.mantissa;
    assign class_mask[4] = !a.fields.sign && a_exp_zero && ~|a.fields.mantissa;
    assign class_mask[5] = !a.fields.sign && a_exp_zero && |a.fields.mantissa;
    assign class_mask[6] = !a.fields.sign && !a_exp_max && !a_exp_zero;
    assign class_mask[7] = !a.fields.sign && a_exp_max && ~|a.fields.mantissa;
    assign class_mask[8] = a_snan;
    assign class_mask[9] = a_nan && !a_snan;

    // ----------------------------------------
    // Result and flags
    // ----------------------------------------
    always_comb begin : p_result
        rsp_d.result = '0;
        rsp_d.status = '0;
        rsp_d.tag    = uop_i.tag;

        case (uop_i.op)
            fpu_pkg::FMIN_MAX: begin
                if (a_nan && b_nan)  rsp_d.result = `FPU_CANON_NAN;
                else if (a_nan)      rsp_d.result = b.raw;  // NaN loses to a number
                else if (b_nan)      rsp_d.result = a.raw;
                else if (uop_i.sub_op[0]) rsp_d.result = a_lt_tot ? b.raw : a.raw;  // Max
                else                 rsp_d.result = a_lt_tot ? a.raw : b.raw;       // Min
                rsp_d.status[`FPU_ST_NV] = any_snan;
            end
            fpu_pkg::FCMP: begin
                case (uop_i.sub_op)
                    `FPU_SUB_LE: begin
                        rsp_d.result[0]          = !any_nan && (a_lt_b || a_eq_b);
                        rsp_d.status[`FPU_ST_NV] = any_nan;   // Signaling compare
                    end
                    `FPU_SUB_LT: begin
                        rsp_d.result[0]          = !any_nan && a_lt_b;
                        rsp_d.status[`FPU_ST_NV] = any_nan;
                    end
                    `FPU_SUB_EQ: begin
                        rsp_d.result[0]          = !any_nan && a_eq_b;
                        rsp_d.status[`FPU_ST_NV] = any_snan;  // Quiet compare
                    end
                    default: ;  // rm 3 returns zero, no flags
                endcase
            end
            default: rsp_d.result = {{(`FPU_FLEN-10){1'b0}}, class_mask};  // FCLASS
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : p_valid
        if (!rst_ni)        valid_o <= 1'b0;
        else if (flush_i)   valid_o <= 1'b0;
        else if (advance_i) valid_o <= valid_i;  // Bubble when not selected
    end

    always_ff @(posedge clk_i) begin : p_data
        if (advance_i && valid_i) rsp_o <= rsp_d;
    end

endmodule

// File: hw/fpu_sgnj_unit.sv
// Sign injection and register moves, one pipeline register, advanced by the output stage
`timescale 1ns/1ps
`include "fpu_defines.svh"

module fpu_sgnj_unit (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              flush_i,
    input  logic              valid_i,
    input  logic              advance_i,
    input  fpu_pkg::fpu_uop_t uop_i,
    output logic              valid_o,
    output fpu_pkg::fpu_rsp_t rsp_o
);

    logic              new_sign;
    fpu_pkg::fpu_rsp_t rsp_d;

    // ----------------------------------------
    // Sign selection
    // ----------------------------------------
    always_comb begin : p_sign
        case (uop_i.sub_op)
            `FPU_SUB_SGNJ:  new_sign = uop_i.operand_b.fields.sign;
            `FPU_SUB_SGNJN: new_sign = ~uop_i.operand_b.fields.sign;
            `FPU_SUB_SGNJX: new_sign = uop_i.operand_a.fields.sign ^ uop_i.operand_b.fields.sign;
            default:        new_sign = uop_i.operand_a.fields.sign;  // Copy keeps A's sign
        endcase

        // Magnitude always from A, copy passes A untouched
        rsp_d.result = {new_sign, uop_i.operand_a.raw[`FPU_FLEN-2:0]};
        rsp_d.status = '0;  // No exceptions possible
        rsp_d.tag    = uop_i.tag;
    end

    // Stage valid, loads a bubble when the other unit was chosen
    always_ff @(posedge clk_i or negedge rst_ni) begin : p_valid
        if (!rst_ni) begin
            valid_o <= 1'b0;
        end else if (flush_i) begin
            valid_o <= 1'b0;
        end else if (advance_i) begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin : p_data
        if (advance_i && valid_i) rsp_o <= rsp_d;
    end

endmodule

// File: hw/fpu_issue_buffer.sv
// Upstream hold register with READY/STALL FSM, steers each micro-op to its execution unit
`timescale 1ns/1ps

module fpu_issue_buffer (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              flush_i,
    input  logic              in_valid_i,
    output logic              in_ready_o,
    input  fpu_pkg::fpu_uop_t uop_i,
    output logic              sgnj_valid_o,
    output logic              cmp_valid_o,
    input  logic              unit_ready_i,
    output fpu_pkg::fpu_uop_t uop_o
);

    typedef enum logic {READY, STALL} state_e;

    state_e            state_q, state_d;
    fpu_pkg::fpu_uop_t uop_q;        // Hold register
    logic              hold_inputs;  // Capture the incoming micro-op
    logic              use_hold;     // Offer the held micro-op downstream
    logic              unit_valid;

    // ----------------------------------------
    // Protocol inversion FSM
    // ----------------------------------------
    always_comb begin : p_fsm
        in_ready_o  = 1'b0;
        unit_valid  = 1'b0;
        hold_inputs = 1'b0;
        use_hold    = 1'b0;
        state_d     = state_q;

        case (state_q)
            READY: begin
                in_ready_o = 1'b1;        // Every valid request is taken here
                unit_valid = in_valid_i;  // Pass straight through
                // Downstream busy, park the request and stall upstream
                if (in_valid_i && !unit_ready_i) begin
                    hold_inputs = 1'b1;
                    state_d     = STALL;
                end
            end
            STALL: begin
                unit_valid = 1'b1;
                use_hold   = 1'b1;
                if (unit_ready_i) state_d = READY;  // Held item consumed
            end
            default: state_d = READY;
        endcase

        // Flush drops the held item
        if (flush_i) state_d = READY;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : p_state
        if (!rst_ni) begin
            state_q <= READY;
        end else begin
            state_q <= state_d;
        end
    end

    // Payload only, validity lives in the FSM state
    always_ff @(posedge clk_i) begin : p_hold
        if (hold_inputs) uop_q <= uop_i;
    end

    // ----------------------------------------
    // Data select and steering
    // ----------------------------------------
    assign uop_o        = use_hold ? uop_q : uop_i;
    assign sgnj_valid_o = unit_valid && (uop_o.unit == fpu_pkg::UNIT_SGNJ);
    assign cmp_valid_o  = unit_valid && (uop_o.unit == fpu_pkg::UNIT_CMP);

endmodule

// File: hw/fpu_op_decode.sv
// Combinational decode of operator and rm field into a micro-op for the sign-injection or compare unit
`timescale 1ns/1ps
`include "fpu_defines.svh"

module fpu_op_decode (
    input  fpu_pkg::fpu_req_t req_i,
    output fpu_pkg::fpu_uop_t uop_o
);

    // ----------------------------------------
    // Operator translation
    // ----------------------------------------
    always_comb begin : p_decode
        // Operands and tag travel unchanged
        uop_o.op            = req_i.op;
        uop_o.operand_a.raw = req_i.operand_a;
        uop_o.operand_b.raw = req_i.operand_b;
        uop_o.tag           = req_i.tag;
        // Unknown operators fall back to a plain move
        uop_o.unit          = fpu_pkg::UNIT_SGNJ;
        uop_o.sub_op        = `FPU_SUB_COPY;

        // rm[2] is ignored for every operator
        case (req_i.op)
            fpu_pkg::FSGNJ: begin
                uop_o.unit   = fpu_pkg::UNIT_SGNJ;
                uop_o.sub_op = req_i.rm[1:0];  // 3 gives a copy
            end

            // Both moves are a raw copy of A, nothing recoded
            fpu_pkg::FMV_F2X,
            fpu_pkg::FMV_X2F: begin
                uop_o.unit   = fpu_pkg::UNIT_SGNJ;
                uop_o.sub_op = `FPU_SUB_COPY;
            end

            fpu_pkg::FMIN_MAX: begin
                uop_o.unit   = fpu_pkg::UNIT_CMP;
                uop_o.sub_op = {1'b0, req_i.rm[0]};  // 0 min, 1 max
            end

            fpu_pkg::FCMP: begin
                uop_o.unit   = fpu_pkg::UNIT_CMP;
                uop_o.sub_op = req_i.rm[1:0];  // le, lt, eq, or 3 for none
            end

            fpu_pkg::FCLASS: begin
                uop_o.unit   = fpu_pkg::UNIT_CMP;
                uop_o.sub_op = 2'd0;  // Classify has no variants
            end

            default: begin
                uop_o.unit   = fpu_pkg::UNIT_SGNJ;
                uop_o.sub_op = `FPU_SUB_COPY;
            end
        endcase
    end

endmodule

// File: hw/fpu_pkg.sv
// Types of the FP32 non-computational unit; every file reaches them through fpu_pkg:: names
`include "fpu_defines.svh"

package fpu_pkg;

    // ----------------------------------------
    // Operators seen at the request port
    // ----------------------------------------
    typedef enum logic [2:0] {
        FSGNJ,     // Sign injection, flavour in rm[1:0]
        FMV_F2X,   // FP register to integer register
        FMV_X2F,   // Integer register to FP register
        FMIN_MAX,  // rm[0] picks min or max
        FCMP,      // rm[1:0] picks le, lt or eq
        FCLASS     // Ten-bit class mask
    } fpu_op_e;

    // IEEE 754 single-precision layout
    typedef struct packed {
        logic       sign;
        logic [7:0] exponent;
        logic [22:0] mantissa;
    } fp32_fields_t;

    // One word, seen either as raw bits or as its fields
    typedef union packed {
        logic [`FPU_FLEN-1:0] raw;
        fp32_fields_t         fields;
    } fp32_u;

    // Incoming request
    typedef struct packed {
        fpu_op_e                  op;
        logic [2:0]               rm;         // Only [1:0] carries meaning
        logic [`FPU_FLEN-1:0]     operand_a;
        logic [`FPU_FLEN-1:0]     operand_b;
        logic [`FPU_TAG_BITS-1:0] tag;
    } fpu_req_t;

    // Execution unit a micro-op is steered to
    typedef enum logic {
        UNIT_SGNJ,
        UNIT_CMP
    } fpu_unit_e;

    // Decoded micro-op, as held in the issue buffer
    typedef struct packed {
        fpu_unit_e                unit;
        fpu_op_e                  op;         // Lets the compare unit tell its three jobs apart
        logic [1:0]               sub_op;
        fp32_u                    operand_a;
        fp32_u                    operand_b;
        logic [`FPU_TAG_BITS-1:0] tag;
    } fpu_uop_t;

    // Response leaving a unit and the output stage
    typedef struct packed {
        logic [`FPU_FLEN-1:0]        result;
        logic [`FPU_STATUS_BITS-1:0] status;
        logic [`FPU_TAG_BITS-1:0]    tag;
    } fpu_rsp_t;

endpackage

// File: hw/fpu_defines.svh
// Widths and encodings of the FP32 non-computational unit, included by RTL and bench alike
`ifndef FPU_DEFINES_SVH
`define FPU_DEFINES_SVH

// ----------------------------------------
// Datapath widths
// ----------------------------------------
`define FPU_FLEN        32  // Operand and result width
`define FPU_TAG_BITS    3   // Transaction tag width
`define FPU_STATUS_BITS 5   // NV DZ OF UF NX, MSB first
`define FPU_ST_NV       4   // Invalid-operation flag position

// Canonical quiet NaN returned when both min/max operands are NaN
`define FPU_CANON_NAN   32'h7FC0_0000

// ----------------------------------------
// Sub-operation codes taken from rm[1:0]
// ----------------------------------------
`define FPU_SUB_SGNJ    2'd0  // B's sign
`define FPU_SUB_SGNJN   2'd1  // Inverted B sign
`define FPU_SUB_SGNJX   2'd2  // A xor B sign
`define FPU_SUB_COPY    2'd3  // Plain move of A
`define FPU_SUB_LE      2'd0
`define FPU_SUB_LT      2'd1
`define FPU_SUB_EQ      2'd2

`endif
